// ==== Bender.yml ====
package:
  name: desTop

sources:
  - include_dirs:
      - include
    files:
      - src/desPkg.sv
      - src/desCoreIf.sv
      - src/desBusRegs.sv
      - src/desKeySchedule.sv
      - src/desBlockState.sv
      - src/desFeistel.sv
      - src/desTop.sv
  - target: test
    files:
      - testbench/desTopTb.sv

// ==== desTop.f ====
+incdir+include
src/desPkg.sv
src/desCoreIf.sv
src/desBusRegs.sv
src/desKeySchedule.sv
src/desBlockState.sv
src/desFeistel.sv
src/desTop.sv
testbench/desTopTb.sv

// ==== include/desSboxTables.svh ====
/* The eight DES S-boxes, indexed [box][row][column] with S1 first.
   Row and column selection from the 6-bit input is done by sboxLookup. */
`ifndef DES_SBOX_TABLES_SVH
`define DES_SBOX_TABLES_SVH

localparam int SboxTable [8][4][16] = '{
	'{'{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7},
	  '{ 0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8},
	  '{ 4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0},
	  '{15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13}},
	'{'{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10},
	  '{ 3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5},
	  '{ 0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15},
	  '{13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9}},
	'{'{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8},
	  '{13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1},
	  '{13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7},
	  '{ 1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12}},
	'{'{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15},
	  '{13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9},
	  '{10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4},
	  '{ 3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14}},
	'{'{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9},
	  '{14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6},
	  '{ 4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14},
	  '{11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3}},
	'{'{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11},
	  '{10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8},
	  '{ 9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6},
	  '{ 4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13}},
	'{'{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1},
	  '{13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6},
	  '{ 1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2},
	  '{ 6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12}},
	'{'{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7},
	  '{ 1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2},
	  '{ 7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8},
	  '{ 2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}}
};

`endif

// ==== src/desBlockState.sv ====
/* Feistel state of the DES core with its round counter.
   Encryption only; a start pulse is ignored while a block is in flight. */
`timescale 1ns/1ps
`default_nettype none

module desBlockState
	import desPkg::*;
(
	input  logic       Clk,
	input  logic       arstN,
	desCoreIf.block    core,
	input  halfT       fOut,
	output halfT       rightHalf,
	output logic [3:0] roundIdx
);
	coreStateE state;
	halfT      leftHalf;
	blockT     ipOut;
	blockT     preOut;
	blockT     iipOut;

	always_comb
	begin
		for (int i = 0; i < 64; i++)
			ipOut[63 - i] = core.plainText[64 - IpTable[i]];
	end

	// The last round's halves are swapped before the inverse permutation.
	assign preOut = {leftHalf ^ fOut, rightHalf};

	always_comb
	begin
		for (int i = 0; i < 64; i++)
			iipOut[63 - i] = preOut[64 - IipTable[i]];
	end

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= Idle;
			roundIdx <= '0;
		end
		else if (state == Idle)
		begin
			if (core.start)
			begin
				state <= Run;
				roundIdx <= '0;
			end
		end
		else
		begin
			roundIdx <= roundIdx + 4'd1;
			if (roundIdx == 4'(NumRounds - 1))
				state <= Idle;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (state == Idle && core.start)
		begin
			leftHalf <= ipOut[63:32];
			rightHalf <= ipOut[31:0];
		end
		else if (state == Run)
		begin
			leftHalf <= rightHalf;
			rightHalf <= leftHalf ^ fOut;
		end

		if (state == Run && roundIdx == 4'(NumRounds - 1))
			core.cipherText <= iipOut;
	end

	assign core.ready = (state == Idle);

endmodule

`default_nettype wire

// ==== src/desBusRegs.sv ====
/* Wishbone classic slave for the DES registers, full 32-bit words only.
   AddrWidth must be at least 3. Writes and Start are dropped while the core
   is busy and for one more cycle, while the result is copied to DataLo/DataHi. */
`timescale 1ns/1ps
`default_nettype none

module desBusRegs
	import desPkg::*;
#(
	parameter int AddrWidth = 3
)
(
	input  logic                 Clk,
	input  logic                 arstN,
	input  logic                 cyc,
	input  logic                 stb,
	input  logic                 we,
	input  logic [AddrWidth-1:0] adr,
	input  halfT                 datMosi,
	output halfT                 datMiso,
	output logic                 ack,
	desCoreIf.regs               core
);
	desRegE regSel;
	logic   inMap;
	logic   request;
	logic   idle;
	logic   wrAccept;
	logic   readyQ;
	logic   resultValid;
	blockT  dataReg;
	blockT  keyReg;

	assign regSel = desRegE'(adr[2:0]);
	assign inMap = ((adr >> 3) == '0);

	// A new access is one that has not been acknowledged yet.
	assign request = cyc && stb && !ack;

	// The cycle after ready rises still belongs to the run.
	assign idle = core.ready && readyQ;
	assign wrAccept = request && we && inMap && idle;
	assign resultValid = core.ready && !readyQ;

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			ack <= 1'b0;
			core.start <= 1'b0;
			readyQ <= 1'b1;
		end
		else
		begin
			ack <= request;
			readyQ <= core.ready;
			// The pulse follows the ack cycle of an accepted Start write.
			core.start <= ack && cyc && stb && we && inMap && (regSel == Start) && idle;
		end
	end

	// The finished ciphertext replaces the plaintext in the data register.
	always_ff @(posedge Clk)
	begin
		if (resultValid)
			dataReg <= core.cipherText;
		else if (wrAccept && regSel == DataLo)
			dataReg[31:0] <= datMosi;
		else if (wrAccept && regSel == DataHi)
			dataReg[63:32] <= datMosi;

		if (wrAccept && regSel == KeyLo)
			keyReg[31:0] <= datMosi;
		else if (wrAccept && regSel == KeyHi)
			keyReg[63:32] <= datMosi;
	end

	assign core.plainText = dataReg;
	assign core.key = keyReg;

	// The key is write-only and Start reads as zero.
	always_comb
	begin
		datMiso = '0;
		if (inMap)
		begin
			case (regSel)
				DataLo:  datMiso = dataReg[31:0];
				DataHi:  datMiso = dataReg[63:32];
				Status:  datMiso = {31'b0, core.ready};
				default: datMiso = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/desCoreIf.sv ====
/* Link between the register block and the DES core.
   start is a one-cycle pulse and is only issued while ready is high. */
`timescale 1ns/1ps
`default_nettype none

interface desCoreIf
	import desPkg::*;
();
	logic  start;
	blockT plainText;
	blockT key;
	blockT cipherText;
	logic  ready;

	modport regs (
		output start, plainText, key,
		input  cipherText, ready
	);

	// The block state owns the result and the ready flag.
	modport block (
		input  start, plainText,
		output cipherText, ready
	);

	modport keys (
		input  start, key
	);
endinterface

`default_nettype wire

// ==== src/desFeistel.sv ====
/* Combinational DES f-function for one round.
   S1 takes the six most significant bits of the mixed value. */
`timescale 1ns/1ps
`default_nettype none

module desFeistel
	import desPkg::*;
(
	input  halfT   rightHalf,
	input  subkeyT subkey,
	output halfT   fOut
);
	subkeyT expanded;
	subkeyT mixed;
	halfT   sOut;

	// Expand R to 48 bits by duplicating the edge bits of each nibble.
	always_comb
	begin
		for (int i = 0; i < 48; i++)
			expanded[47 - i] = rightHalf[32 - ETable[i]];
	end

	assign mixed = expanded ^ subkey;

	always_comb
	begin
		for (int b = 0; b < 8; b++)
			sOut[28 - 4 * b +: 4] = sboxLookup(b, mixed[42 - 6 * b +: 6]);
	end

	always_comb
	begin
		for (int i = 0; i < 32; i++)
			fOut[31 - i] = sOut[32 - PTable[i]];
	end

endmodule

`default_nettype wire

// ==== src/desKeySchedule.sv ====
/* DES key schedule, one subkey per round, driven by the round index.
   Parity bits of the key are ignored. */
`timescale 1ns/1ps
`default_nettype none

module desKeySchedule
	import desPkg::*;
(
	input  logic       Clk,
	input  logic       arstN,
	desCoreIf.keys     core,
	input  logic [3:0] roundIdx,
	output subkeyT     subkey
);
	coreStateE   state;
	logic [55:0] cd;
	logic [55:0] cdInit;
	logic [55:0] cdRot;
	logic [27:0] cHalf;
	logic [27:0] dHalf;

	always_comb
	begin
		for (int i = 0; i < 56; i++)
			cdInit[55 - i] = core.key[64 - Pc1Table[i]];
	end

	// C and D rotate separately, then PC-2 picks 48 of the 56 bits.
	always_comb
	begin
		cHalf = cd[55:28];
		dHalf = cd[27:0];
		if (ShiftTable[roundIdx] == 1)
			cdRot = {cHalf[26:0], cHalf[27], dHalf[26:0], dHalf[27]};
		else
			cdRot = {cHalf[25:0], cHalf[27:26], dHalf[25:0], dHalf[27:26]};
		for (int i = 0; i < 48; i++)
			subkey[47 - i] = cdRot[56 - Pc2Table[i]];
	end

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
			state <= Idle;
		else if (state == Idle && core.start)
			state <= Run;
		else if (state == Run && roundIdx == 4'(NumRounds - 1))
			state <= Idle;
	end

	always_ff @(posedge Clk)
	begin
		if (state == Idle && core.start)
			cd <= cdInit;
		else if (state == Run)
			cd <= cdRot;
	end

endmodule

`default_nettype wire

// ==== src/desPkg.sv ====
/* Shared DES types, register map and permutation tables.
   Table entries use standard DES bit numbers, where bit 1 is the MSB. */
`default_nettype none

package desPkg;

	typedef logic [63:0] blockT;
	typedef logic [31:0] halfT;
	typedef logic [47:0] subkeyT;

	// Word addresses of the host-visible registers.
	typedef enum logic [2:0] {
		DataLo = 3'd0,
		DataHi = 3'd1,
		KeyLo  = 3'd2,
		KeyHi  = 3'd3,
		Start  = 3'd4,
		Status = 3'd5
	} desRegE;

	typedef enum logic {
		Idle,
		Run
	} coreStateE;

	localparam int NumRounds = 16;

	localparam int IpTable [64] = '{
		58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
		62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
		57, 49, 41, 33, 25, 17,  9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
		61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
	};

	localparam int IipTable [64] = '{
		40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
		38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
		36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
		34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41,  9, 49, 17, 57, 25
	};

	localparam int ETable [48] = '{
		32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,  8,  9, 10, 11,
		12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
		22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
	};

	localparam int PTable [32] = '{
		16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
		 2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
	};

	// PC-1 yields C in the upper 28 bits and D in the lower 28 bits.
	localparam int Pc1Table [56] = '{
		57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
		10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
		14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
	};

	localparam int Pc2Table [48] = '{
		14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10, 23, 19, 12,  4,
		26,  8, 16,  7, 27, 20, 13,  2, 41, 52, 31, 37, 47, 55, 30, 40,
		51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
	};

	// Left rotation applied to C and D before each round's PC-2.
	localparam int ShiftTable [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

	`include "desSboxTables.svh"

	// The outer input bits pick the row and the inner four bits pick the column.
	function automatic logic [3:0] sboxLookup(input int box, input logic [5:0] sixBits);
		logic [1:0] row;
		logic [3:0] col;
		row = {sixBits[5], sixBits[0]};
		col = sixBits[4:1];
		return 4'(SboxTable[box][row][col]);
	endfunction

endpackage

`default_nettype wire

// ==== src/desTop.sv ====
/* DES ECB encryption engine behind a Wishbone classic slave.
   Only full 32-bit words are supported, so sel is not decoded. */
`timescale 1ns/1ps
`default_nettype none

module desTop
	import desPkg::*;
#(
	parameter int AddrWidth = 3
)
(
	input  logic                 Clk,
	input  logic                 arstN,
	input  logic                 cyc,
	input  logic                 stb,
	input  logic                 we,
	input  logic [AddrWidth-1:0] adr,
	input  halfT                 datMosi,
	input  logic [3:0]           sel,
	output halfT                 datMiso,
	output logic                 ack
);
	halfT       rightHalf;
	halfT       fOut;
	subkeyT     subkey;
	logic [3:0] roundIdx;

	desCoreIf core ();

	desBusRegs #(
		.AddrWidth(AddrWidth)
	) uBusRegs (
		.Clk(Clk),
		.arstN(arstN),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datMosi(datMosi),
		.datMiso(datMiso),
		.ack(ack),
		.core(core.regs)
	);

	// Key schedule and block state advance in lockstep on roundIdx.
	desKeySchedule uKeySchedule (
		.Clk(Clk),
		.arstN(arstN),
		.core(core.keys),
		.roundIdx(roundIdx),
		.subkey(subkey)
	);

	desBlockState uBlockState (
		.Clk(Clk),
		.arstN(arstN),
		.core(core.block),
		.fOut(fOut),
		.rightHalf(rightHalf),
		.roundIdx(roundIdx)
	);

	desFeistel uFeistel (
		.rightHalf(rightHalf),
		.subkey(subkey),
		.fOut(fOut)
	);

endmodule

`default_nettype wire

// ==== testbench/desTopTb.sv ====
/* Testbench for the DES engine: bus timing, plaintext readback and two known-answer runs.
   Uses AddrWidth = 3 and full-word accesses only; the run stops after MaxCycles cycles. */
`timescale 1ns/1ps
`default_nettype none

module desTopTb
	import desPkg::*;
();
	localparam int AddrWidth = 3;
	// About 40 bus accesses of three cycles each plus two runs of about 20 cycles
	// need well under 300 cycles, so 3000 leaves a wide margin.
	localparam int MaxCycles = 3000;
	localparam int AckWait = 8;
	localparam int MaxPolls = 20;
	localparam int ReadyLatency = 19;

	logic                 Clk;
	logic                 arstN;
	logic                 cyc;
	logic                 stb;
	logic                 we;
	logic [AddrWidth-1:0] adr;
	halfT                 datMosi;
	logic [3:0]           sel;
	halfT                 datMiso;
	logic                 ack;

	int   errors = 0;
	int   checks = 0;
	int   cycleCount = 0;
	int   lastAckCycle = 0;
	logic ackLast = 1'b0;

	desTop #(
		.AddrWidth(AddrWidth)
	) u_desTop (
		.Clk(Clk),
		.arstN(arstN),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datMosi(datMosi),
		.sel(sel),
		.datMiso(datMiso),
		.ack(ack)
	);

	initial
	begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	always @(posedge Clk)
		cycleCount <= cycleCount + 1;

	task automatic logFailure(input string msg);
		errors++;
		$display("FAILED at %0t ns: %s", $time, msg);
	endtask

	task automatic checkWord(input string what, input halfT got, input halfT exp);
		checks++;
		assert (got === exp)
		else
			logFailure($sformatf("%s read 0x%08h, expected 0x%08h", what, got, exp));
	endtask

	task automatic closeRun();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	endtask

	initial
	begin
		wait (cycleCount >= MaxCycles);
		$display("Timeout: the run did not finish within %0d cycles", MaxCycles);
		errors++;
		closeRun();
	end

	// One access never sees ack high on two cycles in a row.
	always @(negedge Clk)
	begin
		if (arstN)
		begin
			assert (!(ack && ackLast))
			else
				logFailure("ack stayed high for more than one cycle");
		end
		ackLast <= ack;
	end

	// Outputs are sampled on falling edges, half a cycle after the DUT updates them.
	task automatic waitAck(output halfT data);
		int waited;
		waited = 0;
		data = '0;
		do
		begin
			@(negedge Clk);
			waited++;
		end
		while (!ack && waited < AckWait);
		checks++;
		assert (ack)
		else
		begin
			errors++;
			$display("Bus error: no ack within %0d cycles of the request", AckWait);
		end
		if (ack)
		begin
			data = datMiso;
			lastAckCycle = cycleCount;
			checks++;
			assert (waited == 2)
			else
				logFailure($sformatf("ack came %0d cycles after stb, expected 1", waited - 1));
		end
		// The request is held through the ack cycle and released on the next edge.
		@(posedge Clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic wbWrite(input desRegE regAddr, input halfT data);
		halfT unused;
		@(posedge Clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b1;
		adr <= AddrWidth'(regAddr);
		datMosi <= data;
		sel <= 4'hF;
		waitAck(unused);
	endtask

	task automatic wbRead(input desRegE regAddr, output halfT data);
		@(posedge Clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b0;
		adr <= AddrWidth'(regAddr);
		sel <= 4'hF;
		waitAck(data);
	endtask

	task automatic waitReady();
		halfT status;
		int   polls;
		polls = 0;
		do
		begin
			wbRead(Status, status);
			polls++;
		end
		while (status[0] !== 1'b1 && polls < MaxPolls);
		checks++;
		assert (status[0] === 1'b1)
		else
		begin
			errors++;
			$display("Core error: ready did not return after %0d Status polls", MaxPolls);
		end
	endtask

	task automatic loadBlock(input blockT key, input blockT plain);
		wbWrite(KeyLo, key[31:0]);
		wbWrite(KeyHi, key[63:32]);
		wbWrite(DataLo, plain[31:0]);
		wbWrite(DataHi, plain[63:32]);
	endtask

	initial
	begin
		halfT rdData;
		halfT rnd0;
		halfT rnd1;
		int   startAck;
		void'($urandom(18));
		arstN = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datMosi = '0;
		sel = '0;
		repeat (8) @(posedge Clk);
		arstN <= 1'b1;

		// After reset the core is ready and every register answers in one cycle.
		wbRead(Status, rdData);
		checkWord("Status after reset", rdData, 32'h1);
		for (int a = 0; a < 6; a++)
			wbRead(desRegE'(a), rdData);

		rnd0 = $urandom();
		rnd1 = $urandom();
		wbWrite(DataLo, rnd0);
		wbWrite(DataHi, rnd1);
		wbRead(DataLo, rdData);
		checkWord("DataLo readback", rdData, rnd0);
		wbRead(DataHi, rdData);
		checkWord("DataHi readback", rdData, rnd1);

		// Known answer 1, with a Status read and a dropped write while busy.
		loadBlock(64'h1334_5779_9BBC_DFF1, 64'h0123_4567_89AB_CDEF);
		wbWrite(Start, 32'h0);
		wbRead(Status, rdData);
		checkWord("Status during run", rdData, 32'h0);
		wbWrite(DataLo, $urandom());
		// The run is still going, so DataLo still holds the plaintext.
		wbRead(DataLo, rdData);
		checkWord("DataLo after busy write", rdData, 32'h89AB_CDEF);
		waitReady();
		wbRead(DataLo, rdData);
		checkWord("Ciphertext 1 low", rdData, 32'h0F0A_B405);
		wbRead(DataHi, rdData);
		checkWord("Ciphertext 1 high", rdData, 32'h85E8_1354);

		// Known answer 2 with back-to-back polling to bound the latency.
		loadBlock(64'h0, 64'h0);
		wbWrite(Start, 32'h0);
		startAck = lastAckCycle;
		waitReady();
		checks++;
		assert (lastAckCycle - startAck <= ReadyLatency)
		else
			logFailure($sformatf("ready read %0d cycles after the Start ack, limit %0d",
				lastAckCycle - startAck, ReadyLatency));
		wbRead(DataLo, rdData);
		checkWord("Ciphertext 2 low", rdData, 32'hC1B1_23A7);
		wbRead(DataHi, rdData);
		checkWord("Ciphertext 2 high", rdData, 32'h8CA6_4DE9);

		closeRun();
	end

endmodule

`default_nettype wire
